// ==== fixed_to_float.sv ====
// fixed point to float converter
`timescale 1ns/1ps
`default_nettype none

module fixed_to_float import float_pkg::*; #(
    parameter int FIXED_W      = 32,
    parameter int FIXED_FRAC_W = 8
) (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire                 in_valid,
    output logic                in_ready,
    input  wire [FIXED_W-1:0]   in_fixed,
    input  wire [TAG_W-1:0]     in_tag,

    float_stream_if.source      out
);

    localparam int CLZ_W = $clog2(FIXED_W + 1);

    // whole pipeline moves together
    logic                   advance;

    logic                   st0_valid;
    logic                   st0_zero;
    logic                   st0_sign;
    logic [FIXED_W-1:0]     st0_mag;
    logic [TAG_W-1:0]       st0_tag;

    logic                   st1_valid;
    logic                   st1_zero;
    logic                   st1_sign;
    logic [FIXED_W-1:0]     st1_mag;
    logic [CLZ_W-1:0]       st1_clz;
    logic [TAG_W-1:0]       st1_tag;

    logic                   st2_valid;
    float_t                 st2_float;
    logic [TAG_W-1:0]       st2_tag;

    logic [CLZ_W-1:0]                   clz_next;
    logic [FIXED_W-1:0]                 norm;
    logic [FIXED_W+FLOAT_FRAC_W-2:0]    frac_ext;
    logic [FLOAT_FRAC_W-1:0]            frac_next;
    int                                 exp_calc;
    logic [FLOAT_EXP_W-1:0]             exp_next;

    assign advance  = !st2_valid || out.ready;
    assign in_ready = advance;

    // ------------------------------
    // stage valid bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
        end else if (advance) begin
            st0_valid <= in_valid;
            st1_valid <= st0_valid;
            st2_valid <= st1_valid;
        end
    end

    // ------------------------------
    // stage 0: sign and magnitude
    // ------------------------------
    // full width magnitude, so the most negative input fits unsigned
    always_ff @(posedge clk) begin
        if (advance) begin
            st0_zero <= (in_fixed == '0);
            st0_sign <= in_fixed[FIXED_W-1];
            st0_mag  <= in_fixed[FIXED_W-1] ? -in_fixed : in_fixed;
            st0_tag  <= in_tag;
        end
    end

    // ------------------------------
    // stage 1: leading zero count
    // ------------------------------
    always_comb begin
        clz_next = CLZ_W'(FIXED_W);
        // scan upward, the highest set bit wins
        for (int i = 0; i < FIXED_W; i++) begin
            if (st0_mag[i]) begin
                clz_next = CLZ_W'(FIXED_W - 1 - i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st1_zero <= st0_zero;
            st1_sign <= st0_sign;
            st1_mag  <= st0_mag;
            st1_clz  <= clz_next;
            st1_tag  <= st0_tag;
        end
    end

    // ------------------------------
    // stage 2: exponent and fraction
    // ------------------------------
    always_comb begin
        norm     = st1_mag << st1_clz;
        // drop the hidden one, pad below so short inputs zero-extend
        frac_ext  = {norm[FIXED_W-2:0], {FLOAT_FRAC_W{1'b0}}};
        frac_next = frac_ext[FIXED_W+FLOAT_FRAC_W-2 -: FLOAT_FRAC_W];
        exp_calc  = FLOAT_BIAS + (FIXED_W - 1 - FIXED_FRAC_W) - int'(st1_clz);
        exp_next  = exp_calc[FLOAT_EXP_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st2_tag <= st1_tag;
            if (st1_zero) begin
                // zero always becomes +0
                st2_float <= '0;
            end else begin
                st2_float.sign <= st1_sign;
                st2_float.exp  <= exp_next;
                st2_float.frac <= frac_next;
            end
        end
    end

    assign out.valid = st2_valid;
    assign out.data  = st2_float;
    assign out.tag   = st2_tag;

endmodule

`default_nettype wire

// ==== float_convert_top.sv ====
// fixed to float conversion top
`timescale 1ns/1ps
`default_nettype none

module float_convert_top import float_pkg::*; #(
    parameter int FIXED_W      = 32,
    parameter int FIXED_FRAC_W = 8,
    parameter int FIFO_DEPTH   = 4
) (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire                 in_valid,
    output wire                 in_ready,
    input  wire [FIXED_W-1:0]   in_fixed,
    input  wire [TAG_W-1:0]     in_tag,

    input  wire post_op_e       mode,
    input  wire signed [7:0]    scale_exp,

    output wire                 out_valid,
    input  wire                 out_ready,
    output wire float_t         out_float,
    output wire [TAG_W-1:0]     out_tag
);

    // converter to FIFO, FIFO to output stage
    float_stream_if conv_if ();
    float_stream_if post_if ();

    fixed_to_float #(
        .FIXED_W      (FIXED_W),
        .FIXED_FRAC_W (FIXED_FRAC_W)
    ) u_conv (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_fixed (in_fixed),
        .in_tag   (in_tag),
        .out      (conv_if.source)
    );

    float_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (conv_if.sink),
        .out   (post_if.source)
    );

    float_post_op u_post (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (post_if.sink),
        .mode      (mode),
        .scale_exp (scale_exp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_float (out_float),
        .out_tag   (out_tag)
    );

endmodule

`default_nettype wire

// ==== float_fifo.sv ====
// float and tag FIFO
`timescale 1ns/1ps
`default_nettype none

module float_fifo import float_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire             clk,
    input  wire             rst_n,

    float_stream_if.sink    in,
    float_stream_if.source  out
);

    localparam int AW = $clog2(FIFO_DEPTH);

    float_t             mem_data [FIFO_DEPTH];
    logic [TAG_W-1:0]   mem_tag  [FIFO_DEPTH];

    // extra msb is the wrap bit
    logic [AW:0]        wr_ptr;
    logic [AW:0]        rd_ptr;

    logic               empty;
    logic               full;
    logic               do_write;
    logic               do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in.ready  = !full;
    assign out.valid = !empty;
    assign out.data  = mem_data[rd_ptr[AW-1:0]];
    assign out.tag   = mem_tag[rd_ptr[AW-1:0]];

    assign do_write = in.valid && !full;
    assign do_read  = out.ready && !empty;

    // ------------------------------
    // pointers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem_data[wr_ptr[AW-1:0]] <= in.data;
            mem_tag[wr_ptr[AW-1:0]]  <= in.tag;
        end
    end

endmodule

`default_nettype wire

// ==== float_pkg.sv ====
// float conversion shared types
`default_nettype none

package float_pkg;

    // ------------------------------
    // single precision field layout
    // ------------------------------
    localparam int FLOAT_EXP_W   = 8;
    localparam int FLOAT_FRAC_W  = 23;
    localparam int FLOAT_BIAS    = 127;

    // exponent field 255 is inf/nan, never produced here
    localparam int FLOAT_MAX_EXP = 254;

    // sideband tag carried with each sample
    localparam int TAG_W         = 4;

    typedef struct packed {
        logic                    sign;
        logic [FLOAT_EXP_W-1:0]  exp;
        logic [FLOAT_FRAC_W-1:0] frac;
    } float_t;

    // ------------------------------
    // output stage operations
    // ------------------------------
    typedef enum logic [1:0] {
        OP_PASS  = 2'd0,
        OP_NEG   = 2'd1,
        OP_ABS   = 2'd2,
        OP_SCALE = 2'd3
    } post_op_e;

endpackage

`default_nettype wire

// ==== float_post_op.sv ====
// float output operation stage
`timescale 1ns/1ps
`default_nettype none

module float_post_op import float_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,

    float_stream_if.sink        in,

    input  wire post_op_e       mode,
    input  wire signed [7:0]    scale_exp,

    output logic                out_valid,
    input  wire                 out_ready,
    output float_t              out_float,
    output logic [TAG_W-1:0]    out_tag
);

    logic                           accept;
    float_t                         result;
    logic signed [FLOAT_EXP_W+1:0]  exp_ext;
    logic signed [FLOAT_EXP_W+1:0]  scale_ext;
    logic signed [FLOAT_EXP_W+1:0]  exp_sum;

    assign in.ready = !out_valid || out_ready;
    assign accept   = in.valid && in.ready;

    // two extra bits cover the full sum range
    assign exp_ext   = (FLOAT_EXP_W+2)'(in.data.exp);
    assign scale_ext = (FLOAT_EXP_W+2)'(scale_exp);
    assign exp_sum   = exp_ext + scale_ext;

    // ------------------------------
    // operation select
    // ------------------------------
    always_comb begin
        result = in.data;
        case (mode)
            OP_NEG: result.sign = !in.data.sign;
            OP_ABS: result.sign = 1'b0;
            OP_SCALE: begin
                // exp field 0 only ever means zero here
                if (in.data.exp != '0) begin
                    if (exp_sum <= 0) begin
                        result.exp  = '0;
                        result.frac = '0;
                    end else if (exp_sum > FLOAT_MAX_EXP) begin
                        result.exp  = FLOAT_EXP_W'(FLOAT_MAX_EXP);
                        result.frac = '1;
                    end else begin
                        result.exp  = exp_sum[FLOAT_EXP_W-1:0];
                    end
                end
            end
            default: result = in.data;
        endcase
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in.ready) begin
            out_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_float <= result;
            out_tag   <= in.tag;
        end
    end

endmodule

`default_nettype wire

// ==== float_stream_if.sv ====
// float stream handshake
`timescale 1ns/1ps
`default_nettype none

interface float_stream_if import float_pkg::*; ();

    logic               valid;
    logic               ready;
    float_t             data;
    logic [TAG_W-1:0]   tag;

    // producer side, data and tag stay put while stalled
    modport source (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fixed to float testbench with Verilator

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_float_convert \
    -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log

grep -q "STATUS: FAIL" sim.log && echo "simulation failed, see sim.log" && exit 1
echo "simulation passed"
exit 0

// ==== tb_float_convert.sv ====
// fixed to float conversion testbench
`timescale 1ns/1ps
`default_nettype none

module tb_float_convert import float_pkg::*; ();

    localparam int FIXED_W      = 32;
    localparam int FIXED_FRAC_W = 8;
    localparam int FIFO_DEPTH   = 4;

    localparam int TRUNC_ITEMS    = 24;
    localparam int BP_ITEMS       = 46;
    // 1 + 9 + 24 + 46 + 16 + 64 items, each allowed 25 cycles of stalls
    localparam int TOTAL_ITEMS    = 160;
    localparam int STALL_MARGIN   = 25;
    localparam int TIMEOUT_CYCLES = TOTAL_ITEMS * STALL_MARGIN;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [FIXED_W-1:0]     in_fixed;
    logic [TAG_W-1:0]       in_tag;
    post_op_e               mode;
    logic signed [7:0]      scale_exp;
    logic                   out_valid;
    logic                   out_ready = 1'b1;
    float_t                 out_float;
    logic [TAG_W-1:0]       out_tag;

    // scoreboard
    float_t                 exp_q [$];
    logic [TAG_W-1:0]       tag_q [$];

    string                  cur_test;
    int                     cycle = 0;
    int                     accept_cycle;
    int                     output_cycle;
    logic [TAG_W-1:0]       next_tag;
    bit                     random_ready = 1'b0;
    int                     stall_left = 0;

    float_convert_top #(
        .FIXED_W      (FIXED_W),
        .FIXED_FRAC_W (FIXED_FRAC_W),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_float_convert_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fixed  (in_fixed),
        .in_tag    (in_tag),
        .mode      (mode),
        .scale_exp (scale_exp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_float (out_float),
        .out_tag   (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // failure reporting and checks
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_float(input float_t expected, input float_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: float expected %h actual %h",
                                     cur_test, expected, actual));
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] expected, input logic [TAG_W-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: tag expected %h actual %h",
                                     cur_test, expected, actual));
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: %s expected %b actual %b",
                                     cur_test, what, expected, actual));
        end
    endtask

    task automatic check_cycles(input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("CHECK FAILED %s: latency expected %0d actual %0d",
                                     cur_test, expected, actual));
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic float_t to_float(input logic [FIXED_W-1:0] fx);
        float_t             f;
        logic [FIXED_W-1:0] mag;
        int                 lead;
        f = '0;
        if (fx != '0) begin
            mag  = fx[FIXED_W-1] ? -fx : fx;
            lead = FIXED_W - 1;
            while (!mag[lead]) begin
                lead--;
            end
            f.sign = fx[FIXED_W-1];
            f.exp  = FLOAT_EXP_W'(FLOAT_BIAS + lead - FIXED_FRAC_W);
            // hidden one falls off the top, low bits are truncated
            if (lead >= FLOAT_FRAC_W) begin
                f.frac = FLOAT_FRAC_W'(mag >> (lead - FLOAT_FRAC_W));
            end else begin
                f.frac = FLOAT_FRAC_W'(mag << (FLOAT_FRAC_W - lead));
            end
        end
        return f;
    endfunction

    function automatic float_t apply_op(input float_t f, input post_op_e op, input int sc);
        float_t r;
        int     e;
        r = f;
        case (op)
            OP_NEG: r.sign = ~f.sign;
            OP_ABS: r.sign = 1'b0;
            OP_SCALE: begin
                if (f.exp != '0) begin
                    e = int'(f.exp) + sc;
                    if (e <= 0) begin
                        r.exp  = '0;
                        r.frac = '0;
                    end else if (e > FLOAT_MAX_EXP) begin
                        r.exp  = FLOAT_EXP_W'(FLOAT_MAX_EXP);
                        r.frac = '1;
                    end else begin
                        r.exp = FLOAT_EXP_W'(e);
                    end
                end
            end
            default: r = f;
        endcase
        return r;
    endfunction

    // ------------------------------
    // stimulus and monitors
    // ------------------------------
    task automatic send_sample(input logic [FIXED_W-1:0] fx);
        float_t expect_f;
        expect_f = apply_op(to_float(fx), mode, int'(scale_exp));
        in_valid = 1'b1;
        in_fixed = fx;
        in_tag   = next_tag;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(expect_f);
        tag_q.push_back(next_tag);
        accept_cycle = cycle;
        next_tag     = next_tag + 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        random_ready = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check_bit("out_valid after drain", 1'b0, out_valid);
    endtask

    // random output stalls, with an occasional long one that fills the FIFO
    always @(negedge clk) begin
        if (!random_ready) begin
            out_ready = 1'b1;
        end else if (stall_left > 0) begin
            out_ready  = 1'b0;
            stall_left = stall_left - 1;
        end else if ($urandom_range(0, 15) == 0) begin
            stall_left = $urandom_range(8, 16);
            out_ready  = 1'b0;
        end else begin
            out_ready = 1'($urandom_range(0, 1));
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("an output was delivered while no item was expected");
            end else begin
                check_float(exp_q.pop_front(), out_float);
                check_tag(tag_q.pop_front(), out_tag);
                output_cycle = cycle;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            report_failure("timeout: the run did not finish within the cycle limit");
        end
    end

    // ------------------------------
    // tests
    // ------------------------------
    task automatic send_mixed_set();
        send_sample(0);
        send_sample(256);
        send_sample(-256);
        send_sample(-832);
        send_sample(1408);
        send_sample(1);
        send_sample(32'h7fff_ffff);
        send_sample(32'h8000_0000);
    endtask

    task automatic test_reset_latency();
        cur_test = "test_reset_latency";
        check_bit("out_valid after reset", 1'b0, out_valid);
        check_bit("in_ready after reset", 1'b1, in_ready);
        send_sample(640);
        drain();
        check_cycles(5, output_cycle - accept_cycle);
    endtask

    task automatic test_convert_basic();
        cur_test = "test_convert_basic";
        send_sample(0);
        send_sample(256);
        send_sample(-256);
        send_sample(128);
        send_sample(-128);
        send_sample(1);
        send_sample(-1);
        send_sample(32'h7fff_ffff);
        send_sample(32'h8000_0000);
        drain();
    endtask

    task automatic test_truncate();
        int                 p;
        logic [FIXED_W-1:0] m;
        cur_test = "test_truncate";
        for (int i = 0; i < TRUNC_ITEMS; i++) begin
            // leading one at bit 24 or above, random bits below it
            p = $urandom_range(24, FIXED_W - 2);
            m = FIXED_W'($urandom()) & ((FIXED_W'(1) << p) - 1'b1);
            m = m | (FIXED_W'(1) << p);
            send_sample($urandom_range(0, 1) ? -m : m);
        end
        drain();
    endtask

    task automatic test_backpressure_order();
        cur_test     = "test_backpressure_order";
        random_ready = 1'b1;
        for (int i = 0; i < BP_ITEMS; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) @(negedge clk);
            end
            send_sample(FIXED_W'($urandom()));
        end
        drain();
    endtask

    task automatic test_sign_ops();
        cur_test = "test_sign_ops";
        mode = OP_NEG;
        send_mixed_set();
        drain();
        mode = OP_ABS;
        send_mixed_set();
        drain();
        mode = OP_PASS;
    endtask

    task automatic run_scale_batch(input int sc);
        scale_exp = 8'(sc);
        send_mixed_set();
        drain();
    endtask

    task automatic test_scale();
        cur_test = "test_scale";
        mode = OP_SCALE;
        run_scale_batch(3);
        run_scale_batch(-5);
        run_scale_batch(1);
        run_scale_batch(-1);
        // 127 + 127 lands on the top exponent, 150 + 127 overflows
        run_scale_batch(127);
        run_scale_batch(-128);
        run_scale_batch(-127);
        run_scale_batch(100);
        mode      = OP_PASS;
        scale_exp = '0;
    endtask

    initial begin
        void'($urandom(32'h5259_7007));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_fixed  = '0;
        in_tag    = '0;
        mode      = OP_PASS;
        scale_exp = '0;
        next_tag  = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_reset_latency();
        test_convert_basic();
        test_truncate();
        test_backpressure_order();
        test_sign_ops();
        test_scale();

        if (exp_q.size() != 0) begin
            report_failure("items were still expected at the end of the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
float_pkg.sv
float_stream_if.sv
fixed_to_float.sv
float_fifo.sv
float_post_op.sv
float_convert_top.sv
tb_float_convert.sv
